//--- logic/load_aligner.sv
// Load aligner: picks one lane of a cache line and aligns, swaps and extends it
`timescale 1ns/1ps

module load_aligner (
	input  logic [wb_defs_pkg::LINE_W-1:0]     line_i,
	input  logic [wb_defs_pkg::LANE_SEL_W-1:0] lane_sel_i,
	input  logic [1:0]                         addr_lo_i,
	input  wb_defs_pkg::load_op_e              load_op_i,
	output logic [wb_defs_pkg::LANE_W-1:0]     aligned_o
);

	logic [wb_defs_pkg::LANE_W-1:0] lane_word;
	logic [7:0]                     byte_val;
	logic [15:0]                    half_val;

	// Lane 0 sits at the top of the line
	always_comb
	begin
		lane_word = line_i[wb_defs_pkg::LINE_W - 1 - lane_sel_i * wb_defs_pkg::LANE_W
			-: wb_defs_pkg::LANE_W];
	end

	// Memory is big-endian, so address 0 is the top byte
	always_comb
	begin
		case (addr_lo_i)
			2'b00: byte_val = lane_word[31:24];
			2'b01: byte_val = lane_word[23:16];
			2'b10: byte_val = lane_word[15:8];
			default: byte_val = lane_word[7:0];
		endcase
	end

	// Halfword with its two bytes swapped
	always_comb
	begin
		if (addr_lo_i[1])
			half_val = {lane_word[7:0], lane_word[15:8]};
		else
			half_val = {lane_word[23:16], lane_word[31:24]};
	end

	always_comb
	begin
		case (load_op_i)
			wb_defs_pkg::LOAD_UBYTE:
				aligned_o = {24'b0, byte_val};
			wb_defs_pkg::LOAD_SBYTE:
				aligned_o = {{24{byte_val[7]}}, byte_val};
			wb_defs_pkg::LOAD_UHALF:
				aligned_o = {16'b0, half_val};
			wb_defs_pkg::LOAD_SHALF:
				aligned_o = {{16{half_val[15]}}, half_val};
			// Word, strided and gather take the whole lane swapped
			default:
				aligned_o = {lane_word[7:0], lane_word[15:8],
					lane_word[23:16], lane_word[31:24]};
		endcase
	end

endmodule

//--- logic/register_read_port.sv
// Register read port: scalar file plus a registered read of a scalar or vector register
`timescale 1ns/1ps

module register_read_port (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              swe_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0] swaddr_i,
	input  logic [wb_defs_pkg::LANE_W-1:0]    swdata_i,
	input  logic                              read_en_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0] read_reg_i,
	input  logic                              read_is_vector_i,
	input  logic [wb_defs_pkg::LINE_W-1:0]    lane_data_i,
	output logic [wb_defs_pkg::LINE_W-1:0]    read_value_o,
	output logic                              read_valid_o
);

	logic [wb_defs_pkg::LANE_W-1:0] scalar_regs [wb_defs_pkg::NUM_REGS];
	logic [wb_defs_pkg::LANE_W-1:0] scalar_word;

	always_ff @(posedge clk)
	begin
		if (swe_i)
			scalar_regs[swaddr_i] <= swdata_i;
	end

	assign scalar_word = scalar_regs[read_reg_i];

	always_ff @(posedge clk)
	begin
		if (reset_i)
			read_valid_o <= 1'b0;
		else
			read_valid_o <= read_en_i;
	end

	// Scalar reads show the same word in every lane
	always_ff @(posedge clk)
	begin
		if (read_en_i)
		begin
			if (read_is_vector_i)
				read_value_o <= lane_data_i;
			else
				read_value_o <= {wb_defs_pkg::NUM_LANES{scalar_word}};
		end
	end

	// Exactly one cycle of read latency, once out of reset
	assert property (@(posedge clk) disable iff (reset_i)
		!$past(reset_i) |-> read_valid_o == $past(read_en_i));

endmodule

//--- logic/vector_lane_bank.sv
// Vector lane bank: one lane's 32-bit slice of every vector register
`timescale 1ns/1ps

module vector_lane_bank (
	input  logic                              clk,
	input  logic                              we_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0] waddr_i,
	input  logic [wb_defs_pkg::LANE_W-1:0]    wdata_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0] raddr_i,
	output logic [wb_defs_pkg::LANE_W-1:0]    rdata_o
);

	logic [wb_defs_pkg::LANE_W-1:0] regs [wb_defs_pkg::NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (we_i)
			regs[waddr_i] <= wdata_i;
	end

	// Read is asynchronous; the read port registers it
	assign rdata_o = regs[raddr_i];

	// A write must target a known register
	assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i));

endmodule

//--- logic/wb_defs_pkg.sv
// Shared sizes and encodings for the vector writeback subsystem
package wb_defs_pkg;

	// Lane 0 holds the most significant 32 bits of a 512-bit value,
	// and the mask bit for lane n is bit (15 - n)
	localparam int NUM_LANES = 16;
	localparam int LANE_W = 32;
	localparam int LINE_W = 512;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS = 32;
	localparam int LANE_SEL_W = 4;

	// Load width and kind, from instruction bits 28:25
	typedef enum logic [3:0] {
		LOAD_UBYTE = 4'd0,
		LOAD_SBYTE = 4'd1,
		LOAD_UHALF = 4'd2,
		LOAD_SHALF = 4'd3,
		LOAD_WORD = 4'd4,
		LOAD_CTRL = 4'd6,
		LOAD_BLOCK = 4'd7,
		LOAD_BLOCK_MASK = 4'd8,
		LOAD_BLOCK_INVMASK = 4'd9,
		LOAD_STRIDED = 4'd10,
		LOAD_STRIDED_MASK = 4'd11,
		LOAD_STRIDED_INVMASK = 4'd12,
		LOAD_GATHER = 4'd13,
		LOAD_GATHER_MASK = 4'd14,
		LOAD_GATHER_INVMASK = 4'd15
	} load_op_e;

	// What the writeback stage commits
	typedef enum logic [1:0] {
		CLASS_ARITH,
		CLASS_SCALAR_LOAD,
		CLASS_BLOCK_LOAD,
		CLASS_STRIDED_LOAD
	} instr_class_e;

endpackage

//--- logic/writeback_core.sv
// Writeback core: writeback stage, vector lane banks and register read port
`timescale 1ns/1ps

module writeback_core (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic [31:0]                         instruction_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0]   writeback_reg_i,
	input  logic                                writeback_is_vector_i,
	input  logic                                has_writeback_i,
	input  logic [wb_defs_pkg::NUM_LANES-1:0]   mask_i,
	input  logic [wb_defs_pkg::LINE_W-1:0]      ddata_i,
	input  logic [wb_defs_pkg::LINE_W-1:0]      result_i,
	input  logic [wb_defs_pkg::LANE_SEL_W-1:0]  reg_lane_select_i,
	input  logic [wb_defs_pkg::LANE_SEL_W-1:0]  cache_lane_select_i,
	input  logic                                read_en_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0]   read_reg_i,
	input  logic                                read_is_vector_i,
	output logic [wb_defs_pkg::LINE_W-1:0]      read_value_o,
	output logic                                read_valid_o
);

	logic                                wb_valid;
	logic                                wb_is_vector;
	logic [wb_defs_pkg::REG_IDX_W-1:0]   wb_reg;
	logic [wb_defs_pkg::LINE_W-1:0]      wb_value;
	logic [wb_defs_pkg::NUM_LANES-1:0]   wb_mask;
	logic [wb_defs_pkg::LINE_W-1:0]      lane_data;

	writeback_stage writeback_stage_i (
		.clk                   (clk),
		.reset_i               (reset_i),
		.instruction_i         (instruction_i),
		.writeback_reg_i       (writeback_reg_i),
		.writeback_is_vector_i (writeback_is_vector_i),
		.has_writeback_i       (has_writeback_i),
		.mask_i                (mask_i),
		.ddata_i               (ddata_i),
		.result_i              (result_i),
		.reg_lane_select_i     (reg_lane_select_i),
		.cache_lane_select_i   (cache_lane_select_i),
		.has_writeback_o       (wb_valid),
		.writeback_is_vector_o (wb_is_vector),
		.writeback_reg_o       (wb_reg),
		.writeback_value_o     (wb_value),
		.mask_o                (wb_mask)
	);

	// Lane n takes the n-th word from the top and mask bit 15 - n
	for (genvar n = 0; n < wb_defs_pkg::NUM_LANES; n++)
	begin : g_lane
		localparam int HI = wb_defs_pkg::LINE_W - 1 - n * wb_defs_pkg::LANE_W;
		logic lane_we;

		assign lane_we = wb_valid & wb_is_vector & wb_mask[wb_defs_pkg::NUM_LANES - 1 - n];

		vector_lane_bank vector_lane_bank_i (
			.clk     (clk),
			.we_i    (lane_we),
			.waddr_i (wb_reg),
			.wdata_i (wb_value[HI -: wb_defs_pkg::LANE_W]),
			.raddr_i (read_reg_i),
			.rdata_o (lane_data[HI -: wb_defs_pkg::LANE_W])
		);
	end

	register_read_port register_read_port_i (
		.clk              (clk),
		.reset_i          (reset_i),
		.swe_i            (wb_valid & ~wb_is_vector),
		.swaddr_i         (wb_reg),
		.swdata_i         (wb_value[wb_defs_pkg::LANE_W-1:0]),
		.read_en_i        (read_en_i),
		.read_reg_i       (read_reg_i),
		.read_is_vector_i (read_is_vector_i),
		.lane_data_i      (lane_data),
		.read_value_o     (read_value_o),
		.read_valid_o     (read_valid_o)
	);

endmodule

//--- logic/writeback_stage.sv
// Writeback stage: selects the committed value and lane mask and registers the commit
`timescale 1ns/1ps

module writeback_stage (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic [31:0]                         instruction_i,
	input  logic [wb_defs_pkg::REG_IDX_W-1:0]   writeback_reg_i,
	input  logic                                writeback_is_vector_i,
	input  logic                                has_writeback_i,
	input  logic [wb_defs_pkg::NUM_LANES-1:0]   mask_i,
	input  logic [wb_defs_pkg::LINE_W-1:0]      ddata_i,
	input  logic [wb_defs_pkg::LINE_W-1:0]      result_i,
	input  logic [wb_defs_pkg::LANE_SEL_W-1:0]  reg_lane_select_i,
	input  logic [wb_defs_pkg::LANE_SEL_W-1:0]  cache_lane_select_i,
	output logic                                has_writeback_o,
	output logic                                writeback_is_vector_o,
	output logic [wb_defs_pkg::REG_IDX_W-1:0]   writeback_reg_o,
	output logic [wb_defs_pkg::LINE_W-1:0]      writeback_value_o,
	output logic [wb_defs_pkg::NUM_LANES-1:0]   mask_o
);

	wb_defs_pkg::load_op_e           load_op;
	wb_defs_pkg::instr_class_e       instr_class;
	logic                            is_mem_op;
	logic [wb_defs_pkg::LANE_W-1:0]  aligned_value;
	logic [wb_defs_pkg::LINE_W-1:0]  swapped_line;
	logic [wb_defs_pkg::LINE_W-1:0]  value_nxt;
	logic [wb_defs_pkg::NUM_LANES-1:0] mask_nxt;

	assign load_op = wb_defs_pkg::load_op_e'(instruction_i[28:25]);
	assign is_mem_op = instruction_i[31:30] == 2'b10;

	// Address low bits still ride in the result for loads
	load_aligner load_aligner_i (
		.line_i     (ddata_i),
		.lane_sel_i (cache_lane_select_i),
		.addr_lo_i  (result_i[1:0]),
		.load_op_i  (load_op),
		.aligned_o  (aligned_value)
	);

	// Control register transfers commit like arithmetic
	always_comb
	begin
		if (!is_mem_op || !instruction_i[29] || load_op == wb_defs_pkg::LOAD_CTRL)
			instr_class = wb_defs_pkg::CLASS_ARITH;
		else if (!load_op[3] && load_op != wb_defs_pkg::LOAD_BLOCK)
			instr_class = wb_defs_pkg::CLASS_SCALAR_LOAD;
		else if (load_op == wb_defs_pkg::LOAD_BLOCK
			|| load_op == wb_defs_pkg::LOAD_BLOCK_MASK
			|| load_op == wb_defs_pkg::LOAD_BLOCK_INVMASK)
			instr_class = wb_defs_pkg::CLASS_BLOCK_LOAD;
		else
			instr_class = wb_defs_pkg::CLASS_STRIDED_LOAD;
	end

	// Byte swap inside every word of the line
	always_comb
	begin
		for (int i = 0; i < wb_defs_pkg::NUM_LANES; i++)
		begin
			swapped_line[i * wb_defs_pkg::LANE_W +: wb_defs_pkg::LANE_W] = {
				ddata_i[i * wb_defs_pkg::LANE_W +: 8],
				ddata_i[i * wb_defs_pkg::LANE_W + 8 +: 8],
				ddata_i[i * wb_defs_pkg::LANE_W + 16 +: 8],
				ddata_i[i * wb_defs_pkg::LANE_W + 24 +: 8]};
		end
	end

	always_comb
	begin
		case (instr_class)
			wb_defs_pkg::CLASS_SCALAR_LOAD:
			begin
				value_nxt = {wb_defs_pkg::NUM_LANES{aligned_value}};
				mask_nxt = '1;
			end
			wb_defs_pkg::CLASS_BLOCK_LOAD:
			begin
				value_nxt = swapped_line;
				mask_nxt = mask_i;
			end
			wb_defs_pkg::CLASS_STRIDED_LOAD:
			begin
				// Only the lane being filled
				value_nxt = {wb_defs_pkg::NUM_LANES{aligned_value}};
				mask_nxt = (16'h8000 >> reg_lane_select_i) & mask_i;
			end
			default:
			begin
				value_nxt = result_i;
				mask_nxt = mask_i;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			has_writeback_o <= 1'b0;
			writeback_is_vector_o <= 1'b0;
			writeback_reg_o <= '0;
			mask_o <= '0;
		end
		else
		begin
			has_writeback_o <= has_writeback_i;
			writeback_is_vector_o <= writeback_is_vector_i;
			writeback_reg_o <= writeback_reg_i;
			mask_o <= mask_nxt;
		end
		writeback_value_o <= value_nxt;
	end

	// No commit may leave the stage right after reset
	assert property (@(posedge clk) reset_i |=> !has_writeback_o);

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the writeback core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module writeback_core_tb -f writeback_core.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vwriteback_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
	exit 0
fi
echo "Simulation did not pass"
exit 1

//--- tb/writeback_core_tb.sv
// Testbench for the writeback core, replaying write and read commands from a file
`timescale 1ns/1ps

module writeback_core_tb;

	logic                                clk = 1'b0;
	logic                                reset_i;
	logic [31:0]                         instruction_i;
	logic [wb_defs_pkg::REG_IDX_W-1:0]   writeback_reg_i;
	logic                                writeback_is_vector_i;
	logic                                has_writeback_i;
	logic [wb_defs_pkg::NUM_LANES-1:0]   mask_i;
	logic [wb_defs_pkg::LINE_W-1:0]      ddata_i;
	logic [wb_defs_pkg::LINE_W-1:0]      result_i;
	logic [wb_defs_pkg::LANE_SEL_W-1:0]  reg_lane_select_i;
	logic [wb_defs_pkg::LANE_SEL_W-1:0]  cache_lane_select_i;
	logic                                read_en_i;
	logic [wb_defs_pkg::REG_IDX_W-1:0]   read_reg_i;
	logic                                read_is_vector_i;
	logic [wb_defs_pkg::LINE_W-1:0]      read_value_o;
	logic                                read_valid_o;

	// Fields of the current command
	logic [7:0]                          kind;
	logic [8*16-1:0]                     name;
	logic [8*128-1:0]                    line;
	logic [31:0]                         f_instr;
	logic [wb_defs_pkg::REG_IDX_W-1:0]   f_reg;
	logic                                f_vec;
	logic [wb_defs_pkg::NUM_LANES-1:0]   f_mask;
	logic [wb_defs_pkg::LANE_SEL_W-1:0]  f_rsel;
	logic [wb_defs_pkg::LANE_SEL_W-1:0]  f_csel;
	logic [wb_defs_pkg::LINE_W-1:0]      f_ddata;
	logic [wb_defs_pkg::LINE_W-1:0]      f_result;
	logic [wb_defs_pkg::LINE_W-1:0]      f_expect;
	int                                  tests = 0;
	int                                  errors = 0;

	writeback_core writeback_core_i (.*);

	always #20 clk = ~clk;

	// One writeback, then an idle cycle so the commit lands before the next read
	task automatic drive_write();
		@(posedge clk);
		instruction_i <= f_instr;
		writeback_reg_i <= f_reg;
		writeback_is_vector_i <= f_vec;
		mask_i <= f_mask;
		reg_lane_select_i <= f_rsel;
		cache_lane_select_i <= f_csel;
		ddata_i <= f_ddata;
		result_i <= f_result;
		has_writeback_i <= 1'b1;
		@(posedge clk);
		has_writeback_i <= 1'b0;
	endtask

	task automatic check_read();
		int waits;
		logic [wb_defs_pkg::LINE_W-1:0] expected;
		// A scalar register shows the same word in every lane
		expected = f_vec ? f_expect : {wb_defs_pkg::NUM_LANES{f_expect[31:0]}};
		@(posedge clk);
		read_en_i <= 1'b1;
		read_reg_i <= f_reg;
		read_is_vector_i <= f_vec;
		@(posedge clk);
		read_en_i <= 1'b0;
		waits = 0;
		@(negedge clk);
		while (!read_valid_o && waits < 8)
		begin
			@(negedge clk);
			waits++;
		end
		tests++;
		if (!read_valid_o)
		begin
			$display("%0s: read of register %0d timed out, no valid seen", name, f_reg);
			errors++;
		end
		else if (waits != 0)
		begin
			$display("%0s: read data came %0d cycles later than one cycle", name, waits);
			errors++;
		end
		else if (read_value_o !== expected)
		begin
			$display("ERR t=%0t %0s: got %h expected %h", $time, name, read_value_o, expected);
			errors++;
		end
		else
		begin
			// Valid is a single-cycle pulse
			@(negedge clk);
			if (read_valid_o !== 1'b0)
			begin
				$display("%0s: read_valid_o stayed high after the read", name);
				errors++;
			end
			else
				$display("pass %0s", name);
		end
	endtask

	initial
	begin
		int fd;
		int code;
		logic idle_bad;
		reset_i = 1'b1;
		instruction_i = '0;
		writeback_reg_i = '0;
		writeback_is_vector_i = 1'b0;
		has_writeback_i = 1'b0;
		mask_i = '0;
		ddata_i = '0;
		result_i = '0;
		reg_lane_select_i = '0;
		cache_lane_select_i = '0;
		read_en_i = 1'b0;
		read_reg_i = '0;
		read_is_vector_i = 1'b0;
		idle_bad = 1'b0;
		repeat (2) @(posedge clk);
		reset_i <= 1'b0;

		// No read issued yet
		repeat (3)
		begin
			@(negedge clk);
			if (read_valid_o !== 1'b0)
				idle_bad = 1'b1;
		end
		tests++;
		if (idle_bad)
		begin
			$display("reset_idle: read_valid_o went high with no read issued");
			errors++;
		end
		else
			$display("pass reset_idle");

		fd = $fopen("tb/writeback_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/writeback_tests.txt");
			errors++;
		end
		else
		begin
			while ($fscanf(fd, "%s", kind) == 1)
			begin
				if (kind == "#")
					code = $fgets(line, fd);
				else if (kind == "W")
				begin
					code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name, f_instr, f_reg,
						f_vec, f_mask, f_rsel, f_csel, f_ddata, f_result);
					if (code != 9)
					begin
						$display("malformed write line in the test file");
						errors++;
					end
					else
						drive_write();
				end
				else if (kind == "R")
				begin
					code = $fscanf(fd, "%s %h %h %h", name, f_reg, f_vec, f_expect);
					if (code != 4)
					begin
						$display("malformed read line in the test file");
						errors++;
					end
					else
						check_read();
				end
				else
				begin
					$display("unknown command in the test file");
					errors++;
				end
			end
			$fclose(fd);
		end

		$display("tests run %0d, failed %0d", tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- tb/writeback_tests.txt
# W name instr reg vec mask reg_lane cache_lane ddata result, all numbers hex
# R name reg vec expected, where a scalar read gives the one word expected in every lane
W vec_fill 00000000 3 1 ffff 0 0 0 11111111222222223333333344444444
W vec_mask 00000000 3 1 0005 0 0 0 aaaaaaaabbbbbbbbccccccccdddddddd
R vec_mask 3 1 11111111bbbbbbbb33333333dddddddd
W ld_ub0 a0000000 1 0 ffff 0 d 8192a3b40000000000000000 0
R ld_ub0 1 0 00000081
W ld_sb1 a2000000 2 0 ffff 0 d 8192a3b40000000000000000 1
R ld_sb1 2 0 ffffff92
W ld_ub2 a0000000 4 0 ffff 0 d 8192a3b40000000000000000 2
R ld_ub2 4 0 000000a3
W ld_sb3 a2000000 5 0 ffff 0 d 8192a3b40000000000000000 3
R ld_sb3 5 0 ffffffb4
W ld_uh0 a4000000 7 0 ffff 0 d 8192a3b40000000000000000 0
R ld_uh0 7 0 00009281
W ld_sh2 a6000000 8 0 ffff 0 d 8192a3b40000000000000000 2
R ld_sh2 8 0 ffffb4a3
W ld_sh0 a6000000 9 0 ffff 0 f 1a2b7c3d 0
R ld_sh0 9 0 00002b1a
W ld_word a8000000 a 0 ffff 0 d 8192a3b40000000000000000 0
R ld_word a 0 b4a39281
W blk_ld ae000000 3 1 000a 0 0 0102030405060708090a0b0c0d0e0f10 0
R blk_ld 3 1 04030201bbbbbbbb0c0b0a09dddddddd
W strided b4000000 3 1 ffff d f 1a2b7c3d 0
W gather_off ba000000 3 1 fffd e f 55667788 0
R strided 3 1 040302013d7c2b1a0c0b0a09dddddddd
W ctrl_xfer ac000000 6 1 ffff 0 d 8192a3b40000000000000000 cafef00d0badbeef1234567800c0ffee
R ctrl_xfer 6 1 cafef00d0badbeef1234567800c0ffee

//--- writeback_core.f
logic/wb_defs_pkg.sv
logic/load_aligner.sv
logic/writeback_stage.sv
logic/vector_lane_bank.sv
logic/register_read_port.sv
logic/writeback_core.sv
tb/writeback_core_tb.sv
